// ==== run_sim.sh ====
#!/bin/bash
# Builds the UART echo testbench with Verilator, runs it and checks the log.
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module uart_echo_tb \
    -f uart_echo_top.f -o uart_echo_sim \
    && ./obj_dir/uart_echo_sim 2>&1 | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "SIMULATION FAILED" sim.log && { echo "Failure found in sim.log"; exit 1; } || exit 0

// ==== source/uart_echo_top.sv ====
/* UART echo top: receiver, case converting FIFO and transmitter. */
`timescale 1ns/10ps
`include "uart_params.svh"

module uart_echo_top
    import uart_pkg::*;
(
    input  logic      clk_i,
    input  logic      arstn_i,
    input  logic      uart_rx_i,
    input  logic      cts_i,
    input  xform_op_e mode_i,
    output logic      uart_tx_o,
    output logic      overrun_o
);

    logic [`UART_DATA_WIDTH-1:0] rx_data;
    logic                        rx_valid;
    logic                        rx_ready;
    logic [`UART_DATA_WIDTH-1:0] q_data;
    logic                        q_valid;
    logic                        q_ready;

    uart_rx i_rx (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .uart_rx_i  (uart_rx_i),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid),
        .rx_ready_i (rx_ready),
        .overrun_o  (overrun_o)
    );

    xform_fifo i_fifo (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .mode_i     (mode_i),
        .wr_data_i  (rx_data),
        .wr_valid_i (rx_valid),
        .wr_ready_o (rx_ready),
        .rd_data_o  (q_data),
        .rd_valid_o (q_valid),
        .rd_ready_i (q_ready)
    );

    uart_tx i_tx (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .tx_data_i  (q_data),
        .tx_valid_i (q_valid),
        .tx_ready_o (q_ready),
        .cts_i      (cts_i),
        .uart_tx_o  (uart_tx_o)
    );

endmodule

// ==== source/uart_params.svh ====
/* Build-time constants for the UART echo: clock, baud rate, data width, buffer depth. */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// System clock in Hz.
`define UART_CLK_FREQ 50_000_000

// 10 clocks per bit at 50 MHz.
`define UART_BAUD_RATE 5_000_000

// Data bits per frame.
`define UART_DATA_WIDTH 8

// Buffer entries, power of two.
`define FIFO_DEPTH 8

`endif

// ==== source/uart_pkg.sv ====
/* Receiver and transmitter state types, case conversion opcodes. */
package uart_pkg;

    typedef enum logic [2:0] {
        RX_IDLE  = 3'd0,
        RX_START = 3'd1,
        RX_DATA  = 3'd2,
        RX_STOP  = 3'd3
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

    // Letters only, other characters pass unchanged.
    typedef enum logic [1:0] {
        XF_PASS  = 2'd0,
        XF_UPPER = 2'd1,
        XF_LOWER = 2'd2,
        XF_SWAP  = 2'd3
    } xform_op_e;

endpackage

// ==== source/uart_rx.sv ====
/* UART receiver with start-bit check and mid-bit sampling.
   The byte is offered with valid/ready during the stop bit. */
`timescale 1ns/10ps
`include "uart_params.svh"

module uart_rx
    import uart_pkg::*;
#(
    parameter int CLK_FREQ   = `UART_CLK_FREQ,
    parameter int BAUD_RATE  = `UART_BAUD_RATE,
    parameter int DATA_WIDTH = `UART_DATA_WIDTH
)(
    input  logic                  clk_i,
    input  logic                  arstn_i,
    input  logic                  uart_rx_i,
    output logic [DATA_WIDTH-1:0] rx_data_o,
    output logic                  rx_valid_o,
    input  logic                  rx_ready_i,
    output logic                  overrun_o
);

    localparam int RATIO  = CLK_FREQ / BAUD_RATE;
    localparam int BAUD_W = $clog2(RATIO);
    localparam int BIT_W  = $clog2(DATA_WIDTH);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(RATIO - 1);
    localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(RATIO / 2 - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(DATA_WIDTH - 1);

    rx_state_e             state;
    logic [1:0]            rx_sync;
    logic                  rx_line;
    logic [BAUD_W-1:0]     baud_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] shreg;
    logic                  baud_done;
    logic                  start_check;
    logic                  sample;

    // Line idles high, so the synchronizer resets to ones.
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx_i};
        end
    end

    assign rx_line     = rx_sync[1];
    assign baud_done   = (baud_cnt == BAUD_LAST);
    assign start_check = (state == RX_START) && (baud_cnt == BAUD_HALF);
    assign sample      = (state == RX_DATA) && baud_done;
    assign rx_data_o   = shreg;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if ((state == RX_IDLE) || baud_done || start_check) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state      <= RX_IDLE;
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
            overrun_o  <= 1'b0;
        end else begin
            overrun_o <= 1'b0;
            if (rx_valid_o && rx_ready_i) begin
                rx_valid_o <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_line) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (start_check) begin
                        state <= rx_line ? RX_IDLE : RX_DATA; // High here is a glitch.
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST) begin
                            state      <= RX_STOP;
                            rx_valid_o <= 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (baud_done) begin
                        state      <= RX_IDLE;
                        rx_valid_o <= 1'b0;
                        overrun_o  <= rx_valid_o && !rx_ready_i; // Nobody took the byte.
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first.
    always_ff @(posedge clk_i) begin
        if (sample) begin
            shreg <= {rx_line, shreg[DATA_WIDTH-1:1]};
        end
    end

    a_valid_in_stop: assert property (@(posedge clk_i) disable iff (!arstn_i)
        rx_valid_o |-> (state == RX_STOP));

endmodule

// ==== source/uart_tx.sv ====
/* UART transmitter with a valid/ready byte input and clear-to-send gating. */
`timescale 1ns/10ps
`include "uart_params.svh"

module uart_tx
    import uart_pkg::*;
#(
    parameter int CLK_FREQ   = `UART_CLK_FREQ,
    parameter int BAUD_RATE  = `UART_BAUD_RATE,
    parameter int DATA_WIDTH = `UART_DATA_WIDTH
)(
    input  logic                  clk_i,
    input  logic                  arstn_i,
    input  logic [DATA_WIDTH-1:0] tx_data_i,
    input  logic                  tx_valid_i,
    output logic                  tx_ready_o,
    input  logic                  cts_i,
    output logic                  uart_tx_o
);

    localparam int RATIO  = CLK_FREQ / BAUD_RATE;
    localparam int BAUD_W = $clog2(RATIO);
    localparam int BIT_W  = $clog2(DATA_WIDTH);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(RATIO - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(DATA_WIDTH - 1);

    tx_state_e             state;
    logic [BAUD_W-1:0]     baud_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [DATA_WIDTH-1:0] shreg;
    logic                  baud_done;
    logic                  load;

    assign tx_ready_o = (state == TX_IDLE) && cts_i; // CTS only gates the frame start.
    assign load       = tx_valid_i && tx_ready_o;
    assign baud_done  = (baud_cnt == BAUD_LAST);

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if ((state == TX_IDLE) || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state     <= TX_IDLE;
            bit_cnt   <= '0;
            uart_tx_o <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    bit_cnt <= '0;
                    if (load) begin
                        state     <= TX_START;
                        uart_tx_o <= 1'b0; // Start bit.
                    end
                end
                TX_START: begin
                    if (baud_done) begin
                        state     <= TX_DATA;
                        uart_tx_o <= shreg[0];
                    end
                end
                TX_DATA: begin
                    if (baud_done) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST) begin
                            state     <= TX_STOP;
                            uart_tx_o <= 1'b1;
                        end else begin
                            uart_tx_o <= shreg[0];
                        end
                    end
                end
                default: begin
                    if (baud_done) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    // Bit 0 always holds the next bit to send.
    always_ff @(posedge clk_i) begin
        if (load) begin
            shreg <= tx_data_i;
        end else if (baud_done && ((state == TX_START) || (state == TX_DATA))) begin
            shreg <= shreg >> 1;
        end
    end

    a_idle_high: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (state == TX_IDLE) |-> uart_tx_o);

endmodule

// ==== source/xform_fifo.sv ====
/* Character FIFO with case conversion on the write path, head offered with valid/ready. */
`timescale 1ns/10ps
`include "uart_params.svh"

module xform_fifo
    import uart_pkg::*;
#(
    parameter int DEPTH = `FIFO_DEPTH
)(
    input  logic       clk_i,
    input  logic       arstn_i,
    input  xform_op_e  mode_i,
    input  logic [7:0] wr_data_i,
    input  logic       wr_valid_i,
    output logic       wr_ready_o,
    output logic [7:0] rd_data_o,
    output logic       rd_valid_o,
    input  logic       rd_ready_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [7:0]       conv_data;
    logic             push;
    logic             pop;

    function automatic logic [7:0] xform(input xform_op_e op, input logic [7:0] c);
        logic is_upper;
        logic is_lower;
        is_upper = (c >= "A") && (c <= "Z");
        is_lower = (c >= "a") && (c <= "z");
        case (op)
            XF_UPPER: return is_lower ? (c ^ 8'h20) : c; // Bit 5 selects the case.
            XF_LOWER: return is_upper ? (c ^ 8'h20) : c;
            XF_SWAP:  return (is_upper || is_lower) ? (c ^ 8'h20) : c;
            default:  return c;
        endcase
    endfunction

    assign conv_data  = xform(mode_i, wr_data_i);
    assign wr_ready_o = (count != FULL);
    assign rd_valid_o = (count != '0);
    assign push       = wr_valid_i && wr_ready_o;
    assign pop        = rd_valid_o && rd_ready_i;
    assign rd_data_o  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= conv_data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two.
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_max: assert property (@(posedge clk_i) disable iff (!arstn_i)
        count <= FULL);

    // A read of an empty buffer must not move the count below zero.
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!arstn_i)
        ((count == '0) && rd_ready_i) |=> (count == CNT_W'($past(push))));

endmodule

// ==== uart_echo_top.f ====
+incdir+source
source/uart_pkg.sv
source/uart_rx.sv
source/xform_fifo.sv
source/uart_tx.sv
source/uart_echo_top.sv
verif/uart_echo_tb.sv

// ==== verif/uart_echo_tb.sv ====
/* Directed testbench for the UART echo with a serial driver and decoder,
   case conversion, back-pressure, overrun and false start tests. */
`timescale 1ns/10ps
`include "uart_params.svh"

module uart_echo_tb
    import uart_pkg::*;
;

    localparam int BIT_CLKS = `UART_CLK_FREQ / `UART_BAUD_RATE;
    // About 40 frames of 100 clocks in and out, plus quiet gaps, with margin.
    localparam int TIMEOUT_CYCLES = 20000;

    logic      clk_i;
    logic      arstn_i;
    logic      uart_rx_i;
    logic      cts_i;
    xform_op_e mode_i;
    logic      uart_tx_o;
    logic      overrun_o;

    logic [7:0] echo_q[$];
    logic [7:0] dec_byte;
    int         dec_i;
    int         ovr_count = 0;
    int         err_count = 0;
    int         pass_tests = 0;
    int         fail_tests = 0;
    int         cycles = 0;

    uart_echo_top i_dut (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .uart_rx_i (uart_rx_i),
        .cts_i     (cts_i),
        .mode_i    (mode_i),
        .uart_tx_o (uart_tx_o),
        .overrun_o (overrun_o)
    );

    always #10 clk_i = ~clk_i;

    // Decoder samples each bit near its middle, on the falling clock edge.
    always begin
        @(negedge uart_tx_o);
        repeat (BIT_CLKS / 2) @(negedge clk_i);
        if (uart_tx_o !== 1'b0) begin
            $display("Error at %0t: start bit on uart_tx_o did not stay low", $time);
            err_count++;
        end else begin
            for (dec_i = 0; dec_i < 8; dec_i++) begin
                repeat (BIT_CLKS) @(negedge clk_i);
                dec_byte[dec_i] = uart_tx_o;
            end
            repeat (BIT_CLKS) @(negedge clk_i);
            if (uart_tx_o !== 1'b1) begin
                $display("Error at %0t: stop bit on uart_tx_o is missing", $time);
                err_count++;
            end
            echo_q.push_back(dec_byte);
        end
    end

    always @(negedge clk_i) begin
        if (arstn_i && overrun_o) begin
            ovr_count++;
        end
    end

    function automatic logic [7:0] model_xform(input xform_op_e op, input logic [7:0] c);
        logic lower;
        logic upper;
        lower = (c >= 8'h61) && (c <= 8'h7a);
        upper = (c >= 8'h41) && (c <= 8'h5a);
        if (((op == XF_UPPER) || (op == XF_SWAP)) && lower) begin
            return c - 8'd32;
        end
        if (((op == XF_LOWER) || (op == XF_SWAP)) && upper) begin
            return c + 8'd32;
        end
        return c;
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int act);
        $display("Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        err_count++;
    endtask

    task automatic record_result(input string name, input int err_before);
        if (err_count == err_before) begin
            $display("Test %s: ok", name);
            pass_tests++;
        end else begin
            $display("Test %s: %0d errors", name, err_count - err_before);
            fail_tests++;
        end
    endtask

    task automatic settle(input int bits);
        repeat (bits * BIT_CLKS) @(negedge clk_i);
    endtask

    // One frame: start bit, 8 data bits LSB first, stop bit.
    task automatic send_byte(input logic [7:0] data);
        int i;
        uart_rx_i = 1'b0;
        repeat (BIT_CLKS) @(negedge clk_i);
        for (i = 0; i < 8; i++) begin
            uart_rx_i = data[i];
            repeat (BIT_CLKS) @(negedge clk_i);
        end
        uart_rx_i = 1'b1;
        repeat (BIT_CLKS) @(negedge clk_i);
    endtask

    task automatic wait_echo(input int count, input int limit_cycles);
        int waited;
        waited = 0;
        while ((echo_q.size() < count) && (waited < limit_cycles)) begin
            @(negedge clk_i);
            waited++;
        end
        if (echo_q.size() < count) begin
            $display("Error at %0t: only %0d of %0d echoed bytes arrived in time",
                     $time, echo_q.size(), count);
            err_count++;
        end
    endtask

    task automatic run_reset_echo();
        int err_before;
        err_before = err_count;
        if (uart_tx_o !== 1'b1) report_mismatch("uart_tx_o", 1, uart_tx_o);
        if (overrun_o !== 1'b0) report_mismatch("overrun_o", 0, overrun_o);
        echo_q.delete();
        send_byte(8'h5a);
        wait_echo(1, 30 * BIT_CLKS);
        settle(20); // Nothing else may follow the echo.
        if (echo_q.size() != 1) report_mismatch("echo count", 1, echo_q.size());
        if (echo_q.size() > 0 && echo_q[0] !== 8'h5a) begin
            report_mismatch("uart_tx_o", 8'h5a, echo_q[0]);
        end
        record_result("reset_echo", err_before);
    endtask

    task automatic conversion_sweep();
        int err_before;
        int k;
        int i;
        string text;
        err_before = err_count;
        text = "aZ3q!";
        for (k = 0; k < 4; k++) begin
            mode_i = xform_op_e'(k);
            echo_q.delete();
            for (i = 0; i < text.len(); i++) begin
                send_byte(text[i]);
            end
            wait_echo(text.len(), 30 * BIT_CLKS);
            for (i = 0; i < echo_q.size(); i++) begin
                if (echo_q[i] !== model_xform(mode_i, text[i])) begin
                    report_mismatch("uart_tx_o", model_xform(mode_i, text[i]), echo_q[i]);
                end
            end
        end
        mode_i = XF_PASS;
        record_result("conversion", err_before);
    endtask

    // Sends n bytes with CTS low, then releases CTS and expects the first 8 back.
    task automatic held_burst(input string name, input int n, input int exp_ovr);
        int err_before;
        int ovr_base;
        int i;
        logic [7:0] data [10];
        err_before = err_count;
        ovr_base = ovr_count;
        echo_q.delete();
        cts_i = 1'b0;
        for (i = 0; i < n; i++) begin
            data[i] = 8'($urandom);
            send_byte(data[i]);
        end
        settle(2);
        if (echo_q.size() != 0) report_mismatch("echo count", 0, echo_q.size());
        if (ovr_count - ovr_base != exp_ovr) begin
            report_mismatch("overrun_o pulses", exp_ovr, ovr_count - ovr_base);
        end
        cts_i = 1'b1;
        wait_echo(8, 100 * BIT_CLKS);
        settle(20);
        if (echo_q.size() != 8) report_mismatch("echo count", 8, echo_q.size());
        for (i = 0; i < echo_q.size() && i < 8; i++) begin
            if (echo_q[i] !== data[i]) report_mismatch("uart_tx_o", data[i], echo_q[i]);
        end
        record_result(name, err_before);
    endtask

    task automatic false_start_reject();
        int err_before;
        int ovr_base;
        err_before = err_count;
        ovr_base = ovr_count;
        echo_q.delete();
        uart_rx_i = 1'b0;
        repeat (3) @(negedge clk_i);
        uart_rx_i = 1'b1;
        settle(25); // Long enough for a wrongly accepted frame to be echoed.
        if (echo_q.size() != 0) report_mismatch("echo count", 0, echo_q.size());
        if (ovr_count != ovr_base) report_mismatch("overrun_o pulses", 0, ovr_count - ovr_base);
        send_byte(8'h96);
        wait_echo(1, 30 * BIT_CLKS);
        if (echo_q.size() > 0 && echo_q[0] !== 8'h96) begin
            report_mismatch("uart_tx_o", 8'h96, echo_q[0]);
        end
        record_result("false_start", err_before);
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hf3f9a28e));
        clk_i = 1'b0;
        arstn_i = 1'b0;
        uart_rx_i = 1'b1;
        cts_i = 1'b1;
        mode_i = XF_PASS;
        repeat (3) @(negedge clk_i);
        arstn_i = 1'b1;
        repeat (2) @(negedge clk_i);
        run_reset_echo();
        conversion_sweep();
        held_burst("backpressure_order", 8, 0);
        held_burst("overrun", 10, 2);
        false_start_reject();
        $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
        if ((fail_tests == 0) && (err_count == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
